//--- filelist.f
soc_pkg.sv
iomem_decode.sv
scratch_ram.sv
gpio_ctrl.sv
led_fb.sv
soc.sv
soc_sva.sv
soc_checker.sv
soc_tb.sv

//--- gpio_ctrl.sv
// GPIO controller with direction, output and input registers.
// Input pins pass a two-flop synchronizer before they can be read.

`timescale 1ns/1ns

module gpio_ctrl #(
    parameter int GPIO_NR = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  soc_pkg::iomem_req_t bus_req,
    output soc_pkg::iomem_rsp_t rsp,
    input  logic [GPIO_NR-1:0]  gpio_in,
    output logic [GPIO_NR-1:0]  gpio_out,
    output logic [GPIO_NR-1:0]  gpio_oe
);
    import soc_pkg::*;

    logic [GPIO_NR-1:0] dir_q;
    logic [GPIO_NR-1:0] out_q;
    logic [GPIO_NR-1:0] in_meta;
    logic [GPIO_NR-1:0] in_sync;
    data_t              rdata_q;
    logic               ready_q;
    logic               wr_en;

    assign wr_en = sel && (bus_req.wstrb != '0);

    // Pin synchronizer
    always_ff @(posedge clk) begin
        if (reset) begin
            in_meta <= '0;
            in_sync <= '0;
        end else begin
            in_meta <= gpio_in;
            in_sync <= in_meta;
        end
    end

    // ------------------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            dir_q   <= '0;
            out_q   <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= sel;
            if (wr_en && bus_req.addr == GPIO_DIR_ADDR) begin
                dir_q <= bus_req.wdata[GPIO_NR-1:0];
            end
            // Input register ignores writes
            if (wr_en && bus_req.addr == GPIO_OUTPUT_ADDR) begin
                out_q <= bus_req.wdata[GPIO_NR-1:0];
            end
        end
    end

    // Read data, zero-extended to the bus width
    always_ff @(posedge clk) begin
        if (sel) begin
            case (bus_req.addr)
                GPIO_DIR_ADDR:    rdata_q <= data_t'(dir_q);
                GPIO_OUTPUT_ADDR: rdata_q <= data_t'(out_q);
                GPIO_INPUT_ADDR:  rdata_q <= data_t'(in_sync);
                default:          rdata_q <= '0;
            endcase
        end
    end

    assign gpio_oe   = dir_q;
    assign gpio_out  = out_q;
    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

endmodule

//--- iomem_decode.sv
// Address decoder for the iomem bus. Steers each request to one target,
// answers unmapped addresses itself and merges the target responses.

`timescale 1ns/1ns

module iomem_decode (
    input  logic                clk,
    input  logic                reset,
    input  soc_pkg::iomem_req_t bus_req,
    output logic                ram_sel,
    output logic                gpio_sel,
    output logic                led_sel,
    input  soc_pkg::iomem_rsp_t ram_rsp,
    input  soc_pkg::iomem_rsp_t gpio_rsp,
    input  soc_pkg::iomem_rsp_t led_rsp,
    output soc_pkg::iomem_rsp_t bus_rsp
);
    import soc_pkg::*;

    logic  ram_hit;
    logic  gpio_hit;
    logic  led_hit;
    logic  miss_sel;
    logic  miss_ready;
    addr_t ram_offset;

    // Offset form keeps the window test correct for any base
    assign ram_offset = bus_req.addr - RAM_BASE;
    assign ram_hit    = ram_offset < addr_t'(RAM_BYTES);
    assign gpio_hit   = (bus_req.addr == GPIO_DIR_ADDR)    ||
                        (bus_req.addr == GPIO_OUTPUT_ADDR) ||
                        (bus_req.addr == GPIO_INPUT_ADDR);
    assign led_hit    = bus_req.addr == LED_FB_ADDR;

    // A target stays deselected in its own ready cycle
    assign ram_sel  = bus_req.valid && ram_hit  && !ram_rsp.ready;
    assign gpio_sel = bus_req.valid && gpio_hit && !gpio_rsp.ready;
    assign led_sel  = bus_req.valid && led_hit  && !led_rsp.ready;
    assign miss_sel = bus_req.valid && !(ram_hit || gpio_hit || led_hit) && !miss_ready;

    // Unmapped responder, keeps the bus from hanging
    always_ff @(posedge clk) begin
        if (reset) begin
            miss_ready <= 1'b0;
        end else begin
            miss_ready <= miss_sel;
        end
    end

    // ------------------------------------------------------------------------
    // Response merge
    // ------------------------------------------------------------------------

    always_comb begin
        bus_rsp.ready = ram_rsp.ready | gpio_rsp.ready | led_rsp.ready | miss_ready;
        if (ram_rsp.ready) begin
            bus_rsp.rdata = ram_rsp.rdata;
        end else if (gpio_rsp.ready) begin
            bus_rsp.rdata = gpio_rsp.rdata;
        end else if (led_rsp.ready) begin
            bus_rsp.rdata = led_rsp.rdata;
        end else begin
            // Misses and idle cycles read as zero
            bus_rsp.rdata = '0;
        end
    end

endmodule

//--- led_fb.sv
// LED framebuffer word on the iomem bus plus a free-running heartbeat.
// The heartbeat is the top bit of the counter.

`timescale 1ns/1ns

module led_fb #(
    parameter int HEARTBEAT_BITS = 24
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  soc_pkg::iomem_req_t bus_req,
    output soc_pkg::iomem_rsp_t rsp,
    output soc_pkg::data_t      led_fb,
    output logic                heartbeat
);
    import soc_pkg::*;

    data_t                     fb_q;
    logic                      ready_q;
    logic [HEARTBEAT_BITS-1:0] hb_cnt;

    // Whole word stored on any strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            fb_q    <= '0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= sel;
            if (sel && bus_req.wstrb != '0) begin
                fb_q <= bus_req.wdata;
            end
        end
    end

    // Blink counter
    always_ff @(posedge clk) begin
        if (reset) begin
            hb_cnt <= '0;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    assign heartbeat = hb_cnt[HEARTBEAT_BITS-1];
    assign led_fb    = fb_q;
    // Read returns the live register, already updated after a write
    assign rsp.ready = ready_q;
    assign rsp.rdata = fb_q;

endmodule

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module soc_tb -f filelist.f -o soc_tb_sim
./obj_dir/soc_tb_sim | tee sim.log
grep -q 'All tests passed!' sim.log

//--- scratch_ram.sv
// Word-addressed scratch RAM on the iomem bus with byte write strobes.
// Responds one cycle after its select with the stored word.

`timescale 1ns/1ns

module scratch_ram (
    input  logic                clk,
    input  logic                reset,
    input  logic                sel,
    input  soc_pkg::iomem_req_t bus_req,
    output soc_pkg::iomem_rsp_t rsp
);
    import soc_pkg::*;

    localparam int unsigned RAM_WORDS = RAM_BYTES / 4;
    localparam int unsigned IDX_BITS  = $clog2(RAM_WORDS);

    data_t                mem [RAM_WORDS];
    logic [IDX_BITS-1:0]  idx;
    data_t                rdata_q;
    logic                 ready_q;

    // Word index from the byte address
    assign idx = bus_req.addr[IDX_BITS+1:2];

    // Storage and read port
    always_ff @(posedge clk) begin
        if (sel) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (bus_req.wstrb[lane]) begin
                    mem[idx][lane*8 +: 8] <= bus_req.wdata[lane*8 +: 8];
                end
            end
            // Old word on a write, the master ignores it
            rdata_q <= mem[idx];
        end
    end

    // One-cycle ready pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= sel;
        end
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

endmodule

//--- soc.sv
// Top level of the iomem peripheral subsystem. One bus master port fans
// out through the decoder to scratch RAM, GPIO and the LED framebuffer.

`timescale 1ns/1ns

module soc #(
    parameter int GPIO_NR        = 8,
    parameter int HEARTBEAT_BITS = 24
) (
    input  logic                clk,
    input  logic                reset,
    input  soc_pkg::iomem_req_t bus_req,
    output soc_pkg::iomem_rsp_t bus_rsp,
    input  logic [GPIO_NR-1:0]  gpio_in,
    output logic [GPIO_NR-1:0]  gpio_out,
    output logic [GPIO_NR-1:0]  gpio_oe,
    output soc_pkg::data_t      led_fb,
    output logic                heartbeat
);
    import soc_pkg::*;

    logic       ram_sel;
    logic       gpio_sel;
    logic       led_sel;
    iomem_rsp_t ram_rsp;
    iomem_rsp_t gpio_rsp;
    iomem_rsp_t led_rsp;

    // ------------------------------------------------------------------------
    // Decoder and targets
    // ------------------------------------------------------------------------

    iomem_decode decode_i (
        .clk      (clk),
        .reset    (reset),
        .bus_req  (bus_req),
        .ram_sel  (ram_sel),
        .gpio_sel (gpio_sel),
        .led_sel  (led_sel),
        .ram_rsp  (ram_rsp),
        .gpio_rsp (gpio_rsp),
        .led_rsp  (led_rsp),
        .bus_rsp  (bus_rsp)
    );

    scratch_ram ram_i (
        .clk     (clk),
        .reset   (reset),
        .sel     (ram_sel),
        .bus_req (bus_req),
        .rsp     (ram_rsp)
    );

    gpio_ctrl #(
        .GPIO_NR (GPIO_NR)
    ) gpio_i (
        .clk      (clk),
        .reset    (reset),
        .sel      (gpio_sel),
        .bus_req  (bus_req),
        .rsp      (gpio_rsp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    led_fb #(
        .HEARTBEAT_BITS (HEARTBEAT_BITS)
    ) led_fb_i (
        .clk       (clk),
        .reset     (reset),
        .sel       (led_sel),
        .bus_req   (bus_req),
        .rsp       (led_rsp),
        .led_fb    (led_fb),
        .heartbeat (heartbeat)
    );

endmodule

//--- soc_checker.sv
// Watches the soc ports and compares them with the expected values that the
// testbench derives from its shadow state. Counts and reports errors.

`timescale 1ns/1ns

module soc_checker #(
    parameter int GPIO_NR        = 8,
    parameter int HEARTBEAT_BITS = 24
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                done,
    input  soc_pkg::iomem_req_t bus_req,
    input  soc_pkg::iomem_rsp_t bus_rsp,
    input  logic [GPIO_NR-1:0]  gpio_out,
    input  logic [GPIO_NR-1:0]  gpio_oe,
    input  soc_pkg::data_t      led_fb,
    input  logic                heartbeat,
    input  logic [8*12-1:0]     test_name,
    input  soc_pkg::data_t      exp_rdata,
    input  logic [GPIO_NR-1:0]  shadow_out,
    input  logic [GPIO_NR-1:0]  shadow_oe,
    input  soc_pkg::data_t      shadow_led,
    output int                  errors
);
    import soc_pkg::*;

    iomem_req_t pend;
    logic       last_valid;
    logic       last_ready;
    logic       last_hb;
    int         quiet;
    int         mismatches = 0;
    int         failures = 0;

    assign errors = mismatches + failures;

    task automatic report_mismatch(string what, data_t expected, data_t actual);
        $display("Mismatch in %0s: %0s expected %h actual %h",
                 test_name, what, expected, actual);
        mismatches++;
    endtask

    task automatic report_failure(string what);
        $display("Error in %0s at %0t: %0s", test_name, $time, what);
        failures++;
    endtask

    // Sampled on the rising edge, before the DUT registers update
    always @(posedge clk) begin
        if (reset) begin
            pend       = '0;
            last_valid = 1'b0;
            last_ready = 1'b0;
            last_hb    = heartbeat;
            quiet      = 0;
        end else begin
            if (bus_rsp.ready && !last_valid) begin
                report_failure("ready without valid");
            end
            if (last_valid && !last_ready && !bus_rsp.ready) begin
                report_failure("ready did not follow valid after one cycle");
            end
            if (bus_rsp.ready && last_ready) begin
                report_failure("ready stayed high for two cycles");
            end
            if (bus_rsp.ready && pend.wstrb == '0 && bus_rsp.rdata !== exp_rdata) begin
                report_mismatch("read data", exp_rdata, bus_rsp.rdata);
            end
            // Pins only while the bus is idle
            if (!bus_req.valid && !last_valid && !bus_rsp.ready) begin
                if (gpio_oe !== shadow_oe) begin
                    report_mismatch("gpio_oe", data_t'(shadow_oe), data_t'(gpio_oe));
                end
                if (gpio_out !== shadow_out) begin
                    report_mismatch("gpio_out", data_t'(shadow_out), data_t'(gpio_out));
                end
                if (led_fb !== shadow_led) begin
                    report_mismatch("led_fb", shadow_led, led_fb);
                end
            end
            quiet = (heartbeat != last_hb) ? 0 : quiet + 1;
            if (quiet == (1 << HEARTBEAT_BITS)) begin
                report_failure("heartbeat did not toggle");
            end
            if (bus_req.valid && !bus_rsp.ready) begin
                pend = bus_req;
            end
            last_valid = bus_req.valid;
            last_ready = bus_rsp.ready;
            last_hb    = heartbeat;
        end
    end

    always @(posedge done) begin
        $display("Checks done: %0d mismatches, %0d other errors", mismatches, failures);
    end

endmodule

//--- soc_pkg.sv
// Shared types and address map for the iomem peripheral subsystem.
// Imported by every RTL module and by the testbench.

package soc_pkg;

    // ------------------------------------------------------------------------
    // Bus word types
    // ------------------------------------------------------------------------

    // Byte address on the iomem bus
    typedef logic [31:0] addr_t;

    // Data word, both directions
    typedef logic [31:0] data_t;

    // Byte lane write strobes, all zero means read
    typedef logic [3:0] strb_t;

    // Request from the bus master, 69 bits
    typedef struct packed {
        logic  valid;
        strb_t wstrb;
        addr_t addr;
        data_t wdata;
    } iomem_req_t;

    // Response back to the master, 33 bits
    typedef struct packed {
        logic  ready;
        data_t rdata;
    } iomem_rsp_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------

    // Scratch RAM window
    localparam addr_t       RAM_BASE  = 32'h0000_0000;
    localparam int unsigned RAM_BYTES = 1024;

    // GPIO register block
    localparam addr_t GPIO_DIR_ADDR    = 32'h1000_0000;
    localparam addr_t GPIO_OUTPUT_ADDR = 32'h1000_0004;
    localparam addr_t GPIO_INPUT_ADDR  = 32'h1000_0008;

    // LED framebuffer word
    localparam addr_t LED_FB_ADDR = 32'h1000_0010;

endpackage

//--- soc_sva.sv
// Concurrent checks on the iomem handshake and the reset state of soc.
// Bound into soc by the testbench.

`timescale 1ns/1ns

module soc_sva #(
    parameter int GPIO_NR = 8
) (
    input logic                clk,
    input logic                reset,
    input soc_pkg::iomem_req_t bus_req,
    input soc_pkg::iomem_rsp_t bus_rsp,
    input logic [GPIO_NR-1:0]  gpio_out,
    input logic [GPIO_NR-1:0]  gpio_oe,
    input soc_pkg::data_t      led_fb
);

    // Ready is a single-cycle pulse
    ready_pulse: assert property (@(posedge clk) disable iff (reset)
        bus_rsp.ready |=> !bus_rsp.ready)
        else $error("ready high two cycles running");

    ready_after_valid: assert property (@(posedge clk) disable iff (reset)
        bus_rsp.ready |-> $past(bus_req.valid))
        else $error("ready without valid in the previous cycle");

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !bus_rsp.ready && gpio_oe == '0 && gpio_out == '0 && led_fb == '0)
        else $error("outputs not quiet after reset");

endmodule

//--- soc_tb.sv
// Testbench for the iomem peripheral subsystem. Drives LCG bus traffic into
// soc, keeps shadow copies of all visible state and feeds the checker.

`timescale 1ns/1ns

module soc_tb;
    import soc_pkg::*;

    localparam int GPIO_NR        = 6;
    localparam int HEARTBEAT_BITS = 4;
    localparam int PERIOD         = 100;
    localparam int RAM_WORDS      = RAM_BYTES / 4;
    localparam int IDX_HI         = $clog2(RAM_BYTES) - 1;
    localparam int N_TXN          = 2 * RAM_WORDS + 100;

    logic               clk;
    logic               reset;
    logic               done;
    iomem_req_t         bus_req;
    iomem_rsp_t         bus_rsp;
    logic [GPIO_NR-1:0] gpio_in;
    logic [GPIO_NR-1:0] gpio_out;
    logic [GPIO_NR-1:0] gpio_oe;
    data_t              led_fb;
    logic               heartbeat;
    logic [8*12-1:0]    test_name;
    data_t              exp_rdata;
    int                 errors;
    logic [31:0]        seed;
    data_t              shadow_ram [RAM_WORDS];
    logic [GPIO_NR-1:0] shadow_oe;
    logic [GPIO_NR-1:0] shadow_out;
    logic [GPIO_NR-1:0] shadow_in;
    data_t              shadow_led;

    soc #(.GPIO_NR(GPIO_NR), .HEARTBEAT_BITS(HEARTBEAT_BITS)) dut_i (.*);
    soc_checker #(.GPIO_NR(GPIO_NR), .HEARTBEAT_BITS(HEARTBEAT_BITS)) check_i (.*);
    bind soc soc_sva #(.GPIO_NR(GPIO_NR)) sva_i (.*);

    // ------------------------------------------------------------------------
    // Stimulus source and reference model
    // ------------------------------------------------------------------------

    function automatic data_t rand_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Expected read word for an address
    function automatic data_t expected_read(addr_t addr);
        if (addr - RAM_BASE < addr_t'(RAM_BYTES)) begin
            return shadow_ram[addr[IDX_HI:2]];
        end
        case (addr)
            GPIO_DIR_ADDR:    return data_t'(shadow_oe);
            GPIO_OUTPUT_ADDR: return data_t'(shadow_out);
            GPIO_INPUT_ADDR:  return data_t'(shadow_in);
            LED_FB_ADDR:      return shadow_led;
            default:          return '0;
        endcase
    endfunction

    // One transaction, writes update the shadow state first
    task automatic bus_access(strb_t wstrb, addr_t addr, data_t wdata);
        int cycles;
        @(negedge clk);
        if (wstrb == '0) begin
            exp_rdata = expected_read(addr);
        end else if (addr - RAM_BASE < addr_t'(RAM_BYTES)) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wstrb[lane]) begin
                    shadow_ram[addr[IDX_HI:2]][lane*8 +: 8] = wdata[lane*8 +: 8];
                end
            end
        end else if (addr == GPIO_DIR_ADDR) begin
            shadow_oe = wdata[GPIO_NR-1:0];
        end else if (addr == GPIO_OUTPUT_ADDR) begin
            shadow_out = wdata[GPIO_NR-1:0];
        end else if (addr == LED_FB_ADDR) begin
            shadow_led = wdata;
        end
        bus_req = '{valid: 1'b1, wstrb: wstrb, addr: addr, wdata: wdata};
        // Bounded wait, a late ready is flagged by the checker
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!bus_rsp.ready && cycles < 4);
        bus_req.valid = 1'b0;
    endtask

    task automatic read_regs();
        bus_access('0, GPIO_DIR_ADDR, '0);
        bus_access('0, GPIO_OUTPUT_ADDR, '0);
        bus_access('0, GPIO_INPUT_ADDR, '0);
        bus_access('0, LED_FB_ADDR, '0);
    endtask

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(PERIOD * (N_TXN * 4 + 100));
        $display("Timeout: the run did not finish within %0d transactions", N_TXN);
        $display("Test failures found");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        addr_t addr;
        data_t word;
        strb_t strb;
        reset      = 1'b1;
        done       = 1'b0;
        bus_req    = '0;
        gpio_in    = '0;
        seed       = 32'hef2c_d7f2;
        exp_rdata  = '0;
        shadow_oe  = '0;
        shadow_out = '0;
        shadow_in  = '0;
        shadow_led = '0;
        test_name  = "reset";
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        read_regs();

        // Fill, strobed writes at random words, full readback
        test_name = "ram_strobe";
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_access(4'hf, RAM_BASE + addr_t'(i * 4), rand_word());
        end
        for (int i = 0; i < 64; i++) begin
            addr = RAM_BASE + (rand_word() & addr_t'(RAM_BYTES - 4));
            word = rand_word();
            strb = (word[31:28] == '0) ? 4'hf : word[31:28];
            bus_access(strb, addr, rand_word());
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_access('0, RAM_BASE + addr_t'(i * 4), '0);
        end

        test_name = "gpio";
        bus_access(4'hf, GPIO_DIR_ADDR, rand_word());
        bus_access(4'h2, GPIO_OUTPUT_ADDR, rand_word());
        read_regs();
        // Held well past the two synchronizer flops
        gpio_in   = GPIO_NR'(rand_word());
        shadow_in = gpio_in;
        repeat (3) @(negedge clk);
        bus_access(4'hf, GPIO_INPUT_ADDR, ~rand_word());
        read_regs();

        test_name = "led_fb";
        bus_access(4'h8, LED_FB_ADDR, rand_word());
        bus_access('0, LED_FB_ADDR, '0);
        repeat (1 << HEARTBEAT_BITS) @(negedge clk);

        test_name = "unmapped";
        addr = 32'h2000_0000 | (rand_word() & 32'h0fff_fffc);
        bus_access('0, addr, '0);
        bus_access(4'hf, addr, rand_word());
        bus_access('0, addr, '0);
        read_regs();
        bus_access('0, RAM_BASE, '0);
        repeat (4) @(negedge clk);

        done = 1'b1;
        #1;
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
